// File: logic/mst_port.sv
//--------------------------------------------------------------------------
// Master port with address decode, one outstanding transaction and DECERR
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module mst_port (
   input  logic                  clk,
   input  logic                  rst_n,
   input  xbar_pkg::mst_req_t    req,
   input  logic                  req_valid,
   output logic                  req_ready,
   output logic [`XBAR_NSLV-1:0] slv_valid,
   input  logic [`XBAR_NSLV-1:0] slv_ready,
   input  xbar_pkg::mst_rsp_t    rsp_in [`XBAR_NSLV],
   input  logic [`XBAR_NSLV-1:0] rsp_in_valid,
   output logic [`XBAR_NSLV-1:0] rsp_in_ready,
   output xbar_pkg::mst_rsp_t    rsp,
   output logic                  rsp_valid,
   input  logic                  rsp_ready
);
   import xbar_pkg::*;

   port_state_e           state_q;
   logic [`XBAR_NSLV-1:0] hit;
   logic [`XBAR_NSLV-1:0] tgt_q;
   mst_id_t               err_id_q;
   mst_rsp_t              sel_rsp;
   logic                  sel_valid;
   logic                  accept;

   //--------------------------------------------------------------------------
   // Request side
   //--------------------------------------------------------------------------
   always_comb begin
      hit = '0;
      hit[`XBAR_SLV_ROM]  = addr_t'(req.addr - `XBAR_ROM_BASE) < `XBAR_ROM_LEN;
      hit[`XBAR_SLV_DRAM] = addr_t'(req.addr - `XBAR_DRAM_BASE) < `XBAR_DRAM_LEN;
   end

   assign slv_valid = (state_q == PS_IDLE && req_valid) ? hit : '0;

   // Unmapped requests are taken right away
   assign req_ready = (state_q == PS_IDLE) && req_valid &&
                      ((|(hit & slv_ready)) || !(|hit));
   assign accept    = req_valid && req_ready;

   //--------------------------------------------------------------------------
   // Response side
   //--------------------------------------------------------------------------
   always_comb begin
      sel_rsp   = '0;
      sel_valid = 1'b0;
      for (int s = 0; s < `XBAR_NSLV; s++) begin
         if (tgt_q[s]) begin
            sel_rsp   = rsp_in[s];
            sel_valid = rsp_in_valid[s];
         end
      end
   end

   always_comb begin
      rsp       = sel_rsp;
      rsp_valid = 1'b0;
      case (state_q)
         PS_WAIT: begin
            rsp_valid = sel_valid;
         end
         PS_DECERR: begin
            rsp       = '{id: err_id_q, rdata: '0, resp: `XBAR_RESP_DECERR};
            rsp_valid = 1'b1;
         end
         default: begin
            rsp_valid = 1'b0;
         end
      endcase
   end

   assign rsp_in_ready = (state_q == PS_WAIT) ? (tgt_q & {`XBAR_NSLV{rsp_ready}}) : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= PS_IDLE;
         tgt_q   <= '0;
      end else begin
         case (state_q)
            PS_IDLE: begin
               if (accept) begin
                  tgt_q   <= hit;
                  state_q <= (|hit) ? PS_WAIT : PS_DECERR;
               end
            end
            PS_WAIT: begin
               if (rsp_valid && rsp_ready) begin
                  state_q <= PS_IDLE;
               end
            end
            PS_DECERR: begin
               if (rsp_ready) begin
                  state_q <= PS_IDLE;
               end
            end
            default: begin
               state_q <= PS_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         err_id_q <= req.id;
      end
   end

endmodule

// File: logic/rr_arbiter.sv
//--------------------------------------------------------------------------
// Round-robin arbiter with grant lock while the winner waits
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module rr_arbiter (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`XBAR_NMST-1:0] req,
   input  logic                  hold,
   output logic [`XBAR_NMST-1:0] gnt,
   output xbar_pkg::mst_idx_t    gnt_idx
);
   import xbar_pkg::*;

   mst_idx_t              ptr_q;
   logic                  lock_q;
   logic [`XBAR_NMST-1:0] gnt_q;
   mst_idx_t              idx_q;
   logic [`XBAR_NMST-1:0] pick;
   mst_idx_t              pick_idx;

   // First requester at or after the pointer
   always_comb begin
      int   j;
      logic found;
      pick     = '0;
      pick_idx = '0;
      found    = 1'b0;
      for (int i = 0; i < `XBAR_NMST; i++) begin
         j = (int'(ptr_q) + i) % `XBAR_NMST;
         if (!found && req[j]) begin
            found    = 1'b1;
            pick[j]  = 1'b1;
            pick_idx = mst_idx_t'(j);
         end
      end
   end

   assign gnt     = lock_q ? gnt_q : pick;
   assign gnt_idx = lock_q ? idx_q : pick_idx;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr_q  <= '0;
         lock_q <= 1'b0;
         gnt_q  <= '0;
         idx_q  <= '0;
      end else begin
         lock_q <= hold;
         gnt_q  <= gnt;
         idx_q  <= gnt_idx;
         // Advance only once the winner is taken
         if ((|gnt) && !hold) begin
            ptr_q <= (gnt_idx == mst_idx_t'(`XBAR_NMST - 1)) ? '0 : gnt_idx + 1'b1;
         end
      end
   end

endmodule

// File: logic/slv_mux.sv
//--------------------------------------------------------------------------
// Slave port with request mux, ID extension and response routing by index
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module slv_mux (
   input  logic                  clk,
   input  logic                  rst_n,
   input  xbar_pkg::mst_req_t    mst_req [`XBAR_NMST],
   input  logic [`XBAR_NMST-1:0] mst_valid,
   output logic [`XBAR_NMST-1:0] mst_ready,
   output xbar_pkg::slv_req_t    req,
   output logic                  req_valid,
   input  logic                  req_ready,
   input  xbar_pkg::slv_rsp_t    rsp,
   input  logic                  rsp_valid,
   output logic                  rsp_ready,
   output xbar_pkg::mst_rsp_t    mst_rsp [`XBAR_NMST],
   output logic [`XBAR_NMST-1:0] mst_rsp_valid,
   input  logic [`XBAR_NMST-1:0] mst_rsp_ready
);
   import xbar_pkg::*;

   logic [`XBAR_NMST-1:0] gnt;
   mst_idx_t              gnt_idx;
   mst_req_t              sel;
   mst_idx_t              rsp_idx;
   logic                  hold;

   rr_arbiter u_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (mst_valid),
      .hold    (hold),
      .gnt     (gnt),
      .gnt_idx (gnt_idx)
   );

   //--------------------------------------------------------------------------
   // Request path
   //--------------------------------------------------------------------------
   assign sel       = mst_req[gnt_idx];
   assign req_valid = |(mst_valid & gnt);
   assign req       = '{id:    {gnt_idx, sel.id},
                        write: sel.write,
                        addr:  sel.addr,
                        wdata: sel.wdata,
                        strb:  sel.strb};

   assign mst_ready = gnt & {`XBAR_NMST{req_ready}};

   // Winner presented but stalled by the slave
   assign hold = req_valid && !req_ready;

   //--------------------------------------------------------------------------
   // Response path
   //--------------------------------------------------------------------------
   assign rsp_idx = rsp.id[`XBAR_SLV_ID_W-1 -: `XBAR_IDX_W];

   always_comb begin
      rsp_ready = 1'b0;
      for (int m = 0; m < `XBAR_NMST; m++) begin
         mst_rsp[m]       = '{id:    rsp.id[`XBAR_ID_W-1:0],
                              rdata: rsp.rdata,
                              resp:  rsp.resp};
         mst_rsp_valid[m] = rsp_valid && (rsp_idx == mst_idx_t'(m));
         if (rsp_idx == mst_idx_t'(m)) begin
            rsp_ready = mst_rsp_ready[m];
         end
      end
   end

endmodule

// File: logic/xbar_consts.svh
//--------------------------------------------------------------------------
// Crossbar sizes, widths, address map and response codes
//--------------------------------------------------------------------------
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

`define XBAR_NMST       3
`define XBAR_NSLV       2
`define XBAR_ADDR_W     32
`define XBAR_DATA_W     32
`define XBAR_STRB_W     (`XBAR_DATA_W / 8)
`define XBAR_ID_W       2
`define XBAR_IDX_W      2
`define XBAR_SLV_ID_W   (`XBAR_IDX_W + `XBAR_ID_W)

// Slave port numbering
`define XBAR_SLV_ROM    0
`define XBAR_SLV_DRAM   1

// Address map
`define XBAR_ROM_BASE   32'h0000_0000
`define XBAR_ROM_LEN    32'h0001_0000
`define XBAR_DRAM_BASE  32'h4000_0000
`define XBAR_DRAM_LEN   32'h4000_0000

`define XBAR_RESP_OKAY    2'd0
`define XBAR_RESP_SLVERR  2'd2
`define XBAR_RESP_DECERR  2'd3

`endif

// File: logic/xbar_pkg.sv
//--------------------------------------------------------------------------
// Crossbar field vectors, request and response structs and port FSM
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

package xbar_pkg;

   typedef logic [`XBAR_ADDR_W-1:0]   addr_t;
   typedef logic [`XBAR_DATA_W-1:0]   data_t;
   typedef logic [`XBAR_STRB_W-1:0]   strb_t;
   typedef logic [`XBAR_ID_W-1:0]     mst_id_t;
   typedef logic [`XBAR_SLV_ID_W-1:0] slv_id_t;
   typedef logic [`XBAR_IDX_W-1:0]    mst_idx_t;
   typedef logic [1:0]                resp_t;

   typedef struct packed {
      mst_id_t id;
      logic    write;
      addr_t   addr;
      data_t   wdata;
      strb_t   strb;
   } mst_req_t;

   // Master index sits above the master ID
   typedef struct packed {
      slv_id_t id;
      logic    write;
      addr_t   addr;
      data_t   wdata;
      strb_t   strb;
   } slv_req_t;

   typedef struct packed {
      mst_id_t id;
      data_t   rdata;
      resp_t   resp;
   } mst_rsp_t;

   typedef struct packed {
      slv_id_t id;
      data_t   rdata;
      resp_t   resp;
   } slv_rsp_t;

   typedef enum logic [1:0] {
      PS_IDLE,
      PS_WAIT,
      PS_DECERR
   } port_state_e;

endpackage

// File: logic/xbar_top.sv
//--------------------------------------------------------------------------
// Crossbar top level with three master ports and the ROM and DRAM ports
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module xbar_top (
   input  logic                  clk,
   input  logic                  rst_n,
   // Masters
   input  xbar_pkg::mst_req_t    mst_req [`XBAR_NMST],
   input  logic [`XBAR_NMST-1:0] mst_req_valid,
   output logic [`XBAR_NMST-1:0] mst_req_ready,
   output xbar_pkg::mst_rsp_t    mst_rsp [`XBAR_NMST],
   output logic [`XBAR_NMST-1:0] mst_rsp_valid,
   input  logic [`XBAR_NMST-1:0] mst_rsp_ready,
   // ROM
   output xbar_pkg::slv_req_t    rom_req,
   output logic                  rom_req_valid,
   input  logic                  rom_req_ready,
   input  xbar_pkg::slv_rsp_t    rom_rsp,
   input  logic                  rom_rsp_valid,
   output logic                  rom_rsp_ready,
   // DRAM
   output xbar_pkg::slv_req_t    dram_req,
   output logic                  dram_req_valid,
   input  logic                  dram_req_ready,
   input  xbar_pkg::slv_rsp_t    dram_rsp,
   input  logic                  dram_rsp_valid,
   output logic                  dram_rsp_ready
);
   import xbar_pkg::*;

   // Indexed by master, then slave
   logic [`XBAR_NSLV-1:0] m_valid     [`XBAR_NMST];
   logic [`XBAR_NSLV-1:0] m_ready     [`XBAR_NMST];
   mst_rsp_t              m_rsp       [`XBAR_NMST][`XBAR_NSLV];
   logic [`XBAR_NSLV-1:0] m_rsp_valid [`XBAR_NMST];
   logic [`XBAR_NSLV-1:0] m_rsp_ready [`XBAR_NMST];
   // Indexed by slave, then master
   logic [`XBAR_NMST-1:0] s_valid     [`XBAR_NSLV];
   logic [`XBAR_NMST-1:0] s_ready     [`XBAR_NSLV];
   mst_rsp_t              s_rsp       [`XBAR_NSLV][`XBAR_NMST];
   logic [`XBAR_NMST-1:0] s_rsp_valid [`XBAR_NSLV];
   logic [`XBAR_NMST-1:0] s_rsp_ready [`XBAR_NSLV];

   for (genvar m = 0; m < `XBAR_NMST; m++) begin : g_mst
      mst_port u_mst (
         .clk          (clk),
         .rst_n        (rst_n),
         .req          (mst_req[m]),
         .req_valid    (mst_req_valid[m]),
         .req_ready    (mst_req_ready[m]),
         .slv_valid    (m_valid[m]),
         .slv_ready    (m_ready[m]),
         .rsp_in       (m_rsp[m]),
         .rsp_in_valid (m_rsp_valid[m]),
         .rsp_in_ready (m_rsp_ready[m]),
         .rsp          (mst_rsp[m]),
         .rsp_valid    (mst_rsp_valid[m]),
         .rsp_ready    (mst_rsp_ready[m])
      );

      for (genvar s = 0; s < `XBAR_NSLV; s++) begin : g_xpose
         assign s_valid[s][m]     = m_valid[m][s];
         assign m_ready[m][s]     = s_ready[s][m];
         assign m_rsp[m][s]       = s_rsp[s][m];
         assign m_rsp_valid[m][s] = s_rsp_valid[s][m];
         assign s_rsp_ready[s][m] = m_rsp_ready[m][s];
      end
   end

   //--------------------------------------------------------------------------
   // Slave ports
   //--------------------------------------------------------------------------
   slv_mux u_rom (
      .clk           (clk),
      .rst_n         (rst_n),
      .mst_req       (mst_req),
      .mst_valid     (s_valid[`XBAR_SLV_ROM]),
      .mst_ready     (s_ready[`XBAR_SLV_ROM]),
      .req           (rom_req),
      .req_valid     (rom_req_valid),
      .req_ready     (rom_req_ready),
      .rsp           (rom_rsp),
      .rsp_valid     (rom_rsp_valid),
      .rsp_ready     (rom_rsp_ready),
      .mst_rsp       (s_rsp[`XBAR_SLV_ROM]),
      .mst_rsp_valid (s_rsp_valid[`XBAR_SLV_ROM]),
      .mst_rsp_ready (s_rsp_ready[`XBAR_SLV_ROM])
   );

   slv_mux u_dram (
      .clk           (clk),
      .rst_n         (rst_n),
      .mst_req       (mst_req),
      .mst_valid     (s_valid[`XBAR_SLV_DRAM]),
      .mst_ready     (s_ready[`XBAR_SLV_DRAM]),
      .req           (dram_req),
      .req_valid     (dram_req_valid),
      .req_ready     (dram_req_ready),
      .rsp           (dram_rsp),
      .rsp_valid     (dram_rsp_valid),
      .rsp_ready     (dram_rsp_ready),
      .mst_rsp       (s_rsp[`XBAR_SLV_DRAM]),
      .mst_rsp_valid (s_rsp_valid[`XBAR_SLV_DRAM]),
      .mst_rsp_ready (s_rsp_ready[`XBAR_SLV_DRAM])
   );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module xbar_tb -f tb.f -o xbar_sim

out=$(./obj_dir/xbar_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
   exit 0
fi
exit 1

// File: tb.f
+incdir+logic
logic/xbar_pkg.sv
logic/rr_arbiter.sv
logic/mst_port.sv
logic/slv_mux.sv
logic/xbar_top.sv
test/xbar_props.sv
test/xbar_tb.sv

// File: test/xbar_props.sv
//--------------------------------------------------------------------------
// Crossbar assertions for handshake hold, ROM range and quiet reset release
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module xbar_props (
   input logic                  clk,
   input logic                  rst_n,
   input xbar_pkg::slv_req_t    rom_req,
   input logic                  rom_req_valid,
   input logic                  rom_req_ready,
   input xbar_pkg::slv_req_t    dram_req,
   input logic                  dram_req_valid,
   input logic                  dram_req_ready,
   input xbar_pkg::mst_rsp_t    mst_rsp [`XBAR_NMST],
   input logic [`XBAR_NMST-1:0] mst_rsp_valid,
   input logic [`XBAR_NMST-1:0] mst_rsp_ready
);
   import xbar_pkg::*;

   a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rom_req_valid && !rom_req_ready |=> rom_req_valid && $stable(rom_req))
      else $error("ROM request dropped or changed before ready");

   a_dram_hold: assert property (@(posedge clk) disable iff (!rst_n)
      dram_req_valid && !dram_req_ready |=> dram_req_valid && $stable(dram_req))
      else $error("DRAM request dropped or changed before ready");

   for (genvar m = 0; m < `XBAR_NMST; m++) begin : g_rsp
      a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
         mst_rsp_valid[m] && !mst_rsp_ready[m] |=> mst_rsp_valid[m] && $stable(mst_rsp[m]))
         else $error("Master response dropped or changed before ready");
   end

   // Only ROM addresses may reach the ROM
   a_rom_range: assert property (@(posedge clk) disable iff (!rst_n)
      rom_req_valid |-> addr_t'(rom_req.addr - `XBAR_ROM_BASE) < `XBAR_ROM_LEN)
      else $error("ROM request outside the ROM range");

   a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !rom_req_valid && !dram_req_valid && (mst_rsp_valid == '0))
      else $error("DUT valid high right after reset release");

endmodule

bind xbar_top xbar_props u_props (
   .clk            (clk),
   .rst_n          (rst_n),
   .rom_req        (rom_req),
   .rom_req_valid  (rom_req_valid),
   .rom_req_ready  (rom_req_ready),
   .dram_req       (dram_req),
   .dram_req_valid (dram_req_valid),
   .dram_req_ready (dram_req_ready),
   .mst_rsp        (mst_rsp),
   .mst_rsp_valid  (mst_rsp_valid),
   .mst_rsp_ready  (mst_rsp_ready)
);

// File: test/xbar_tb.sv
//--------------------------------------------------------------------------
// Crossbar testbench with random masters, ROM and DRAM slave models,
// reference model, compare tasks and watchdog
//--------------------------------------------------------------------------
`include "xbar_consts.svh"

module xbar_tb;
   import xbar_pkg::*;

   localparam int          NTXN       = 150;
   localparam logic [31:0] SEED       = 32'h74d40bfd;
   localparam int          CLK_PERIOD = 20;
   localparam int          WDOG_TIME  = `XBAR_NMST * NTXN * 40 * CLK_PERIOD;
   localparam int          TGT_NONE   = `XBAR_NSLV;

   logic                  clk;
   logic                  rst_n;
   mst_req_t              mst_req [`XBAR_NMST];
   logic [`XBAR_NMST-1:0] mst_req_valid;
   logic [`XBAR_NMST-1:0] mst_req_ready;
   mst_rsp_t              mst_rsp [`XBAR_NMST];
   logic [`XBAR_NMST-1:0] mst_rsp_valid;
   logic [`XBAR_NMST-1:0] mst_rsp_ready;
   wire slv_req_t         slv_req [`XBAR_NSLV];
   wire [`XBAR_NSLV-1:0]  slv_req_valid;
   logic [`XBAR_NSLV-1:0] slv_req_ready;
   slv_rsp_t              slv_rsp [`XBAR_NSLV];
   logic [`XBAR_NSLV-1:0] slv_rsp_valid;
   wire [`XBAR_NSLV-1:0]  slv_rsp_ready;

   logic [31:0]           rng_q    [`XBAR_NMST + `XBAR_NSLV];
   int                    cur_tgt  [`XBAR_NMST];
   // Masters that must be served at a slave before this one again
   logic [`XBAR_NMST-1:0] blockers [`XBAR_NSLV][`XBAR_NMST];
   data_t                 ref_mem  [addr_t];
   data_t                 dram_mem [addr_t];

   xbar_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .mst_req        (mst_req),
      .mst_req_valid  (mst_req_valid),
      .mst_req_ready  (mst_req_ready),
      .mst_rsp        (mst_rsp),
      .mst_rsp_valid  (mst_rsp_valid),
      .mst_rsp_ready  (mst_rsp_ready),
      .rom_req        (slv_req[`XBAR_SLV_ROM]),
      .rom_req_valid  (slv_req_valid[`XBAR_SLV_ROM]),
      .rom_req_ready  (slv_req_ready[`XBAR_SLV_ROM]),
      .rom_rsp        (slv_rsp[`XBAR_SLV_ROM]),
      .rom_rsp_valid  (slv_rsp_valid[`XBAR_SLV_ROM]),
      .rom_rsp_ready  (slv_rsp_ready[`XBAR_SLV_ROM]),
      .dram_req       (slv_req[`XBAR_SLV_DRAM]),
      .dram_req_valid (slv_req_valid[`XBAR_SLV_DRAM]),
      .dram_req_ready (slv_req_ready[`XBAR_SLV_DRAM]),
      .dram_rsp       (slv_rsp[`XBAR_SLV_DRAM]),
      .dram_rsp_valid (slv_rsp_valid[`XBAR_SLV_DRAM]),
      .dram_rsp_ready (slv_rsp_ready[`XBAR_SLV_DRAM])
   );

   //--------------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input int k);
      logic [31:0] x;
      x        = rng_q[k];
      x        = x ^ (x << 13);
      x        = x ^ (x >> 17);
      x        = x ^ (x << 5);
      rng_q[k] = x;
      return x;
   endfunction

   // Unwritten DRAM words
   function automatic data_t dram_fill(input addr_t a);
      return {a[15:0], a[31:16]} ^ 32'h3C3C_C3C3;
   endfunction

   function automatic data_t apply_strobe(input data_t old, input data_t wdata,
                                          input strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < `XBAR_STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input string exp_s, input string act_s);
      abort_run($sformatf("[FAIL] %s: expected %s, actual %s", name, exp_s, act_s));
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
      end
   endtask

   task automatic check_resp(input string name, input resp_t exp, input resp_t act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
      end
   endtask

   task automatic check_id(input string name, input mst_id_t exp, input mst_id_t act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
      end
   endtask

   task automatic check_strb(input string name, input strb_t exp, input strb_t act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
      end
   endtask

   //--------------------------------------------------------------------------
   // Slave side checks of routing, ID extension and round-robin order
   //--------------------------------------------------------------------------
   task automatic check_request(input int s, input slv_req_t r);
      int    idx;
      string tag;
      idx = int'(r.id[`XBAR_SLV_ID_W-1 -: `XBAR_IDX_W]);
      if (idx >= `XBAR_NMST) begin
         abort_run("slave request carries a master index with no master behind it");
      end
      if (!mst_req_valid[idx] || cur_tgt[idx] != s) begin
         abort_run("request reached a slave that its master did not address");
      end
      tag = $sformatf("slave %0d from m%0d", s, idx);
      check_id({tag, " id"}, mst_req[idx].id, r.id[`XBAR_ID_W-1:0]);
      check_addr({tag, " addr"}, mst_req[idx].addr, r.addr);
      check_data({tag, " wdata"}, mst_req[idx].wdata, r.wdata);
      check_strb({tag, " strb"}, mst_req[idx].strb, r.strb);
      check_flag({tag, " write"}, mst_req[idx].write, r.write);
      if (blockers[s][idx] != '0) begin
         abort_run($sformatf("m%0d accepted twice at slave %0d ahead of a waiting master",
                             idx, s));
      end
      for (int k = 0; k < `XBAR_NMST; k++) begin
         blockers[s][k][idx] = 1'b0;
         blockers[s][idx][k] = (k != idx) && mst_req_valid[k] && (cur_tgt[k] == s);
      end
   endtask

   task automatic run_slave(input int s);
      slv_req_t r;
      slv_rsp_t p;
      forever begin
         repeat (xorshift(`XBAR_NMST + s) % 4) @(posedge clk);
         slv_req_ready[s] <= 1'b1;
         do @(negedge clk); while (!slv_req_valid[s]);
         r = slv_req[s];
         check_request(s, r);
         @(posedge clk);
         slv_req_ready[s] <= 1'b0;
         p = '{id: r.id, rdata: '0, resp: `XBAR_RESP_OKAY};
         if (s == `XBAR_SLV_ROM) begin
            if (r.write) begin
               p.resp = `XBAR_RESP_SLVERR;
            end else begin
               p.rdata = r.addr ^ 32'hA5A5_5A5A;
            end
         end else begin
            if (!dram_mem.exists(r.addr)) begin
               dram_mem[r.addr] = dram_fill(r.addr);
            end
            if (r.write) begin
               dram_mem[r.addr] = apply_strobe(dram_mem[r.addr], r.wdata, r.strb);
            end else begin
               p.rdata = dram_mem[r.addr];
            end
         end
         repeat (xorshift(`XBAR_NMST + s) % 4) @(posedge clk);
         slv_rsp[s]       <= p;
         slv_rsp_valid[s] <= 1'b1;
         do @(negedge clk); while (!slv_rsp_ready[s]);
         @(posedge clk);
         slv_rsp_valid[s] <= 1'b0;
      end
   endtask

   //--------------------------------------------------------------------------
   // Random master with its reference model
   //--------------------------------------------------------------------------
   task automatic run_master(input int m);
      mst_req_t    r;
      mst_rsp_t    exp;
      logic [31:0] x;
      int          pick;
      string       tag;
      for (int t = 0; t < NTXN; t++) begin
         repeat (xorshift(m) % 4) @(posedge clk);
         x       = xorshift(m);
         pick    = int'(xorshift(m) % 100);
         r.id    = x[1:0];
         r.write = x[2];
         r.strb  = x[7:4];
         r.wdata = xorshift(m);
         exp     = '{id: r.id, rdata: '0, resp: `XBAR_RESP_OKAY};
         if (pick < 60) begin
            // Each master owns its own DRAM window
            r.addr = `XBAR_DRAM_BASE | (addr_t'(m) << 20) | {26'h0, x[13:10], 2'b00};
            if (!ref_mem.exists(r.addr)) begin
               ref_mem[r.addr] = dram_fill(r.addr);
            end
            if (r.write) begin
               ref_mem[r.addr] = apply_strobe(ref_mem[r.addr], r.wdata, r.strb);
            end else begin
               exp.rdata = ref_mem[r.addr];
            end
            cur_tgt[m] = `XBAR_SLV_DRAM;
         end else if (pick < 85) begin
            r.addr = `XBAR_ROM_BASE | {16'h0, x[23:10], 2'b00};
            if (r.write) begin
               exp.resp = `XBAR_RESP_SLVERR;
            end else begin
               exp.rdata = r.addr ^ 32'hA5A5_5A5A;
            end
            cur_tgt[m] = `XBAR_SLV_ROM;
         end else begin
            r.addr     = x[8] ? {1'b1, x[31:1]} : (32'h0001_0000 | {2'b00, x[31:2]});
            exp.resp   = `XBAR_RESP_DECERR;
            cur_tgt[m] = TGT_NONE;
         end
         mst_req[m]       <= r;
         mst_req_valid[m] <= 1'b1;
         do begin
            @(negedge clk);
            if (mst_rsp_valid[m]) begin
               abort_run($sformatf("m%0d got a response with no request outstanding", m));
            end
         end while (!mst_req_ready[m]);
         @(posedge clk);
         mst_req_valid[m] <= 1'b0;
         repeat (xorshift(m) % 4) @(posedge clk);
         mst_rsp_ready[m] <= 1'b1;
         do @(negedge clk); while (!mst_rsp_valid[m]);
         tag = $sformatf("m%0d txn %0d", m, t);
         check_id({tag, " id"}, exp.id, mst_rsp[m].id);
         check_data({tag, " rdata"}, exp.rdata, mst_rsp[m].rdata);
         check_resp({tag, " resp"}, exp.resp, mst_rsp[m].resp);
         @(posedge clk);
         mst_rsp_ready[m] <= 1'b0;
      end
   endtask

   //--------------------------------------------------------------------------
   // Clock, reset, run and watchdog
   //--------------------------------------------------------------------------
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WDOG_TIME);
      abort_run("watchdog expired before every master finished its transactions");
   end

   initial begin
      rst_n         <= 1'b0;
      mst_req_valid <= '0;
      mst_rsp_ready <= '0;
      slv_req_ready <= '0;
      slv_rsp_valid <= '0;
      for (int k = 0; k < `XBAR_NMST; k++) begin
         mst_req[k] <= '0;
         cur_tgt[k] = TGT_NONE;
      end
      for (int s = 0; s < `XBAR_NSLV; s++) begin
         slv_rsp[s] <= '0;
         for (int k = 0; k < `XBAR_NMST; k++) begin
            blockers[s][k] = '0;
         end
      end
      for (int k = 0; k < `XBAR_NMST + `XBAR_NSLV; k++) begin
         rng_q[k] = SEED ^ (32'(k) * 32'h9E37_79B9);
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      fork
         run_slave(`XBAR_SLV_ROM);
         run_slave(`XBAR_SLV_DRAM);
      join_none
      fork
         run_master(0);
         run_master(1);
         run_master(2);
      join
      // Nothing may stay pending once every master has its last response
      @(negedge clk);
      if (mst_rsp_valid == '0 && slv_req_valid == '0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         abort_run("a response or slave request was left over after the last transaction");
      end
   end

endmodule
